// ==== logic/mixer_pkg.sv ====
package mixer_pkg;

  // **************************************************
  // widths
  // **************************************************

  // sample memory word address
  localparam int ADDR_WIDTH = 18;
  // audio word, signed two's complement
  localparam int DATA_WIDTH = 16;
  // one table entry per trigger input
  localparam int NUM_SAMPLES = 4;

  // apb bus widths
  localparam int APB_ADDR_WIDTH = 8;
  localparam int APB_DATA_WIDTH = 32;

  // **************************************************
  // register map, byte offsets
  // **************************************************

  // base of sample k at 8*k, length at 8*k + 4
  localparam logic [APB_ADDR_WIDTH-1:0] REG_BASE0  = 8'h00;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_LEN0   = 8'h04;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_BASE1  = 8'h08;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_LEN1   = 8'h0c;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_BASE2  = 8'h10;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_LEN2   = 8'h14;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_BASE3  = 8'h18;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_LEN3   = 8'h1c;
  // read-only voice active mask
  localparam logic [APB_ADDR_WIDTH-1:0] REG_STATUS = 8'h20;

  // **************************************************
  // structs
  // **************************************************

  // one sample table entry
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] base;
    logic [ADDR_WIDTH-1:0] length;
  } sample_ent_t;

  // apb master to slave
  typedef struct packed {
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [APB_DATA_WIDTH-1:0] pwdata;
  } apb_req_t;

  // apb slave to master
  typedef struct packed {
    logic [APB_DATA_WIDTH-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
  } apb_rsp_t;

  // address range handed to a voice on load
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] first_addr;
    logic [ADDR_WIDTH-1:0] last_addr;
  } voice_load_t;

  // what each voice tracker reports
  typedef struct packed {
    logic                  active;
    logic [ADDR_WIDTH-1:0] addr;
  } voice_state_t;

endpackage

// ==== logic/sample_table_regs.sv ====
`timescale 1ns/1ps

module sample_table_regs #(
  parameter int NUM_VOICES = 4
) (
  input  logic                                              clk,
  input  logic                                              reset_n,
  input  mixer_pkg::apb_req_t                               apb_req,
  output mixer_pkg::apb_rsp_t                               apb_rsp,
  input  mixer_pkg::voice_state_t [NUM_VOICES-1:0]          voice_states,
  output mixer_pkg::sample_ent_t  [mixer_pkg::NUM_SAMPLES-1:0] sample_table
);

  logic                  access;
  logic                  bad_offset;
  logic [NUM_VOICES-1:0] active_mask;

  // **************************************************
  // decode
  // **************************************************

  // access phase of a transfer
  assign access = apb_req.psel & apb_req.penable;

  // past status or not word aligned
  assign bad_offset = (apb_req.paddr > mixer_pkg::REG_STATUS) ||
                      (apb_req.paddr[1:0] != 2'b00);

  // status word, bit v is voice v
  always_comb begin
    for (int v = 0; v < NUM_VOICES; v++) begin
      active_mask[v] = voice_states[v].active;
    end
  end

  // **************************************************
  // table writes
  // **************************************************

  // lands on the edge that ends the access cycle
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      sample_table <= '0;
    end else if (access && apb_req.pwrite && !bad_offset) begin
      case (apb_req.paddr)
        mixer_pkg::REG_BASE0: sample_table[0].base   <= apb_req.pwdata[mixer_pkg::ADDR_WIDTH-1:0];
        mixer_pkg::REG_LEN0:  sample_table[0].length <= apb_req.pwdata[mixer_pkg::ADDR_WIDTH-1:0];
        mixer_pkg::REG_BASE1: sample_table[1].base   <= apb_req.pwdata[mixer_pkg::ADDR_WIDTH-1:0];
        mixer_pkg::REG_LEN1:  sample_table[1].length <= apb_req.pwdata[mixer_pkg::ADDR_WIDTH-1:0];
        mixer_pkg::REG_BASE2: sample_table[2].base   <= apb_req.pwdata[mixer_pkg::ADDR_WIDTH-1:0];
        mixer_pkg::REG_LEN2:  sample_table[2].length <= apb_req.pwdata[mixer_pkg::ADDR_WIDTH-1:0];
        mixer_pkg::REG_BASE3: sample_table[3].base   <= apb_req.pwdata[mixer_pkg::ADDR_WIDTH-1:0];
        mixer_pkg::REG_LEN3:  sample_table[3].length <= apb_req.pwdata[mixer_pkg::ADDR_WIDTH-1:0];
        // status is read only, write quietly dropped
        default: ;
      endcase
    end
  end

  // **************************************************
  // response
  // **************************************************

  always_comb begin
    apb_rsp.pready  = 1'b1;
    apb_rsp.pslverr = access & bad_offset;
    // entries come back zero extended
    case (apb_req.paddr)
      mixer_pkg::REG_BASE0:  apb_rsp.prdata = mixer_pkg::APB_DATA_WIDTH'(sample_table[0].base);
      mixer_pkg::REG_LEN0:   apb_rsp.prdata = mixer_pkg::APB_DATA_WIDTH'(sample_table[0].length);
      mixer_pkg::REG_BASE1:  apb_rsp.prdata = mixer_pkg::APB_DATA_WIDTH'(sample_table[1].base);
      mixer_pkg::REG_LEN1:   apb_rsp.prdata = mixer_pkg::APB_DATA_WIDTH'(sample_table[1].length);
      mixer_pkg::REG_BASE2:  apb_rsp.prdata = mixer_pkg::APB_DATA_WIDTH'(sample_table[2].base);
      mixer_pkg::REG_LEN2:   apb_rsp.prdata = mixer_pkg::APB_DATA_WIDTH'(sample_table[2].length);
      mixer_pkg::REG_BASE3:  apb_rsp.prdata = mixer_pkg::APB_DATA_WIDTH'(sample_table[3].base);
      mixer_pkg::REG_LEN3:   apb_rsp.prdata = mixer_pkg::APB_DATA_WIDTH'(sample_table[3].length);
      mixer_pkg::REG_STATUS: apb_rsp.prdata = mixer_pkg::APB_DATA_WIDTH'(active_mask);
      // unmapped and unaligned read as zero
      default:               apb_rsp.prdata = '0;
    endcase
  end

endmodule

// ==== logic/voice_allocator.sv ====
`timescale 1ns/1ps

module voice_allocator #(
  parameter int NUM_VOICES = 4
) (
  input  logic                                                 clk,
  input  logic                                                 reset_n,
  input  logic [mixer_pkg::NUM_SAMPLES-1:0]                    triggers,
  input  mixer_pkg::sample_ent_t  [mixer_pkg::NUM_SAMPLES-1:0] sample_table,
  input  mixer_pkg::voice_state_t [NUM_VOICES-1:0]             voice_states,
  output logic [NUM_VOICES-1:0]                                load,
  output mixer_pkg::voice_load_t                               load_info
);

  localparam int SEL_WIDTH = $clog2(mixer_pkg::NUM_SAMPLES);

  // per sample address range, precomputed
  mixer_pkg::voice_load_t [mixer_pkg::NUM_SAMPLES-1:0] range_q;
  logic [mixer_pkg::NUM_SAMPLES-1:0]                   len_ok_q;

  logic [SEL_WIDTH-1:0]  sel_idx;
  logic                  trig_any;
  logic [NUM_VOICES-1:0] free_onehot;
  logic                  free_any;

  // **************************************************
  // address range table
  // **************************************************

  // keeps the base + length - 1 adder out of the trigger path
  // follows a table write one cycle later
  always_ff @(posedge clk) begin
    for (int k = 0; k < mixer_pkg::NUM_SAMPLES; k++) begin
      range_q[k].first_addr <= sample_table[k].base;
      range_q[k].last_addr  <= sample_table[k].base + sample_table[k].length - 1'b1;
    end
  end

  // zero length never starts a voice
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      len_ok_q <= '0;
    end else begin
      for (int k = 0; k < mixer_pkg::NUM_SAMPLES; k++) begin
        len_ok_q[k] <= (sample_table[k].length != '0);
      end
    end
  end

  // **************************************************
  // selection
  // **************************************************

  // lowest trigger bit wins, scan from the top down
  always_comb begin
    sel_idx  = '0;
    trig_any = 1'b0;
    for (int k = mixer_pkg::NUM_SAMPLES - 1; k >= 0; k--) begin
      if (triggers[k]) begin
        sel_idx  = SEL_WIDTH'(k);
        trig_any = 1'b1;
      end
    end
  end

  // lowest inactive voice
  always_comb begin
    free_onehot = '0;
    free_any    = 1'b0;
    for (int v = 0; v < NUM_VOICES; v++) begin
      if (!voice_states[v].active && !free_any) begin
        free_onehot[v] = 1'b1;
        free_any       = 1'b1;
      end
    end
  end

  // one load per cycle, dropped if busy or empty
  assign load      = (trig_any && free_any && len_ok_q[sel_idx]) ? free_onehot : '0;
  assign load_info = range_q[sel_idx];

endmodule

// ==== logic/voice_tracker.sv ====
`timescale 1ns/1ps

module voice_tracker (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   load,
  input  mixer_pkg::voice_load_t load_info,
  input  logic                   advance,
  output mixer_pkg::voice_state_t state
);

  logic [mixer_pkg::ADDR_WIDTH-1:0] addr_q;
  logic [mixer_pkg::ADDR_WIDTH-1:0] last_q;
  logic                             active_q;
  logic                             step;
  logic                             at_last;

  // **************************************************
  // step control
  // **************************************************

  // advance only means something while playing
  assign step    = advance & active_q;
  assign at_last = (addr_q == last_q);

  // **************************************************
  // active flag
  // **************************************************

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      active_q <= 1'b0;
    end else if (load) begin
      active_q <= 1'b1;
    end else if (step && at_last) begin
      // last word has been mixed, retire
      active_q <= 1'b0;
    end
  end

  // **************************************************
  // address walk
  // **************************************************

  always_ff @(posedge clk) begin
    if (load) begin
      addr_q <= load_info.first_addr;
      last_q <= load_info.last_addr;
    end else if (step && !at_last) begin
      addr_q <= addr_q + 1'b1;
    end
  end

  // status out
  assign state.active = active_q;
  assign state.addr   = addr_q;

endmodule

// ==== logic/mix_sequencer.sv ====
`timescale 1ns/1ps

module mix_sequencer #(
  parameter int NUM_VOICES = 4
) (
  input  logic                                     clk,
  input  logic                                     reset_n,
  input  mixer_pkg::voice_state_t [NUM_VOICES-1:0] voice_states,
  output logic [NUM_VOICES-1:0]                    advance,
  output logic [mixer_pkg::ADDR_WIDTH-1:0]         mem_addr,
  input  logic [mixer_pkg::DATA_WIDTH-1:0]         mem_rd_data,
  input  logic                                     fifo_full,
  output logic                                     fifo_wr_en,
  output logic [mixer_pkg::DATA_WIDTH-1:0]         fifo_data
);

  // headroom for NUM_VOICES full scale words
  localparam int SUM_WIDTH  = mixer_pkg::DATA_WIDTH + $clog2(NUM_VOICES);
  localparam int SLOT_WIDTH = $clog2(NUM_VOICES);

  // clamp limits in sum width
  localparam logic signed [SUM_WIDTH-1:0] SAT_MAX = (1 <<< (mixer_pkg::DATA_WIDTH - 1)) - 1;
  localparam logic signed [SUM_WIDTH-1:0] SAT_MIN = -(1 <<< (mixer_pkg::DATA_WIDTH - 1));

  typedef enum logic [1:0] {
    IDLE,
    COLLECT,
    WRITE
  } seq_state_e;

  seq_state_e                   state_q;
  seq_state_e                   state_d;
  logic [SLOT_WIDTH-1:0]        slot_q;
  logic [NUM_VOICES-1:0]        mask_q;
  logic [NUM_VOICES-1:0]        active_vec;
  logic signed [SUM_WIDTH-1:0]  sum_q;
  logic signed [SUM_WIDTH-1:0]  word_ext;
  logic                         last_slot;

  // **************************************************
  // frame state machine
  // **************************************************

  always_comb begin
    for (int v = 0; v < NUM_VOICES; v++) begin
      active_vec[v] = voice_states[v].active;
    end
  end

  assign last_slot = (slot_q == SLOT_WIDTH'(NUM_VOICES - 1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      // fifo_full only looked at here
      IDLE:    if (!fifo_full && (active_vec != '0)) state_d = COLLECT;
      // one voice per cycle
      COLLECT: if (last_slot) state_d = WRITE;
      WRITE:   state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state_q <= IDLE;
      slot_q  <= '0;
    end else begin
      state_q <= state_d;
      // slot only counts during collect
      if (state_q == COLLECT) begin
        slot_q <= slot_q + 1'b1;
      end else begin
        slot_q <= '0;
      end
    end
  end

  // **************************************************
  // accumulate
  // **************************************************

  // voice under the slot drives the memory
  assign mem_addr = voice_states[slot_q].addr;

  // sign extend, masked voices add zero
  assign word_ext = mask_q[slot_q] ?
                    {{(SUM_WIDTH - mixer_pkg::DATA_WIDTH){mem_rd_data[mixer_pkg::DATA_WIDTH-1]}},
                     mem_rd_data} : '0;

  always_ff @(posedge clk) begin
    if (state_q == IDLE) begin
      // voices loaded later wait for the next frame
      mask_q <= active_vec;
      sum_q  <= '0;
    end else if (state_q == COLLECT) begin
      sum_q <= sum_q + word_ext;
    end
  end

  // **************************************************
  // output
  // **************************************************

  assign fifo_wr_en = (state_q == WRITE);
  assign advance    = (state_q == WRITE) ? mask_q : '0;

  // saturate to 16 bit signed
  always_comb begin
    if (sum_q > SAT_MAX) begin
      fifo_data = SAT_MAX[mixer_pkg::DATA_WIDTH-1:0];
    end else if (sum_q < SAT_MIN) begin
      fifo_data = SAT_MIN[mixer_pkg::DATA_WIDTH-1:0];
    end else begin
      fifo_data = sum_q[mixer_pkg::DATA_WIDTH-1:0];
    end
  end

endmodule

// ==== logic/audio_mixer_top.sv ====
`timescale 1ns/1ps

module audio_mixer_top #(
  parameter int NUM_VOICES = 4
) (
  input  logic                              clk,
  input  logic                              reset_n,
  input  mixer_pkg::apb_req_t               apb_req,
  output mixer_pkg::apb_rsp_t               apb_rsp,
  input  logic [mixer_pkg::NUM_SAMPLES-1:0] triggers,
  output logic [mixer_pkg::ADDR_WIDTH-1:0]  mem_addr,
  input  logic [mixer_pkg::DATA_WIDTH-1:0]  mem_rd_data,
  input  logic                              fifo_full,
  output logic                              fifo_wr_en,
  output logic [mixer_pkg::DATA_WIDTH-1:0]  fifo_data
);

  // table from the register block to the allocator
  mixer_pkg::sample_ent_t  [mixer_pkg::NUM_SAMPLES-1:0] sample_table;
  // tracker status, fanned out to regs, allocator and sequencer
  mixer_pkg::voice_state_t [NUM_VOICES-1:0]             voice_states;
  mixer_pkg::voice_load_t                               load_info;
  logic [NUM_VOICES-1:0]                                load;
  logic [NUM_VOICES-1:0]                                advance;

  // **************************************************
  // register block
  // **************************************************

  sample_table_regs #(
    .NUM_VOICES   (NUM_VOICES)
  ) u_regs (
    .clk          (clk),
    .reset_n      (reset_n),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .voice_states (voice_states),
    .sample_table (sample_table)
  );

  // **************************************************
  // voice allocation and tracking
  // **************************************************

  voice_allocator #(
    .NUM_VOICES   (NUM_VOICES)
  ) u_alloc (
    .clk          (clk),
    .reset_n      (reset_n),
    .triggers     (triggers),
    .sample_table (sample_table),
    .voice_states (voice_states),
    .load         (load),
    .load_info    (load_info)
  );

  // one tracker per voice, load info shared
  for (genvar g = 0; g < NUM_VOICES; g++) begin : gen_voice
    voice_tracker u_tracker (
      .clk       (clk),
      .reset_n   (reset_n),
      .load      (load[g]),
      .load_info (load_info),
      .advance   (advance[g]),
      .state     (voice_states[g])
    );
  end

  // **************************************************
  // mixing
  // **************************************************

  mix_sequencer #(
    .NUM_VOICES   (NUM_VOICES)
  ) u_seq (
    .clk          (clk),
    .reset_n      (reset_n),
    .voice_states (voice_states),
    .advance      (advance),
    .mem_addr     (mem_addr),
    .mem_rd_data  (mem_rd_data),
    .fifo_full    (fifo_full),
    .fifo_wr_en   (fifo_wr_en),
    .fifo_data    (fifo_data)
  );

endmodule

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic reset_n
);

  // free running clock
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // reset held low for RESET_CYCLES edges, released on a falling edge
  initial begin
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
  end

endmodule

// ==== bench/audio_mixer_tb.sv ====
`timescale 1ns/1ps

module audio_mixer_tb;

  localparam int NUM_VOICES = 4;
  localparam int AW         = mixer_pkg::ADDR_WIDTH;
  localparam int DW         = mixer_pkg::DATA_WIDTH;
  // shortest spacing of two fifo writes
  localparam int FRAME      = NUM_VOICES + 2;
  // limit well above the length of all tests together
  localparam int MAX_CYCLES = 20000;

  logic                clk;
  logic                reset_n;
  mixer_pkg::apb_req_t apb_req;
  mixer_pkg::apb_rsp_t apb_rsp;
  logic [3:0]          triggers;
  logic [AW-1:0]       mem_addr;
  logic [DW-1:0]       mem_rd_data;
  logic                fifo_full;
  logic                fifo_wr_en;
  logic [DW-1:0]       fifo_data;

  // reference voices
  logic [NUM_VOICES-1:0] ref_active;
  logic [AW-1:0]         ref_addr [NUM_VOICES];
  logic [AW-1:0]         ref_last [NUM_VOICES];
  // shadow of the sample table
  logic [AW-1:0]         tab_base [4];
  logic [AW-1:0]         tab_len  [4];

  int cycle_count = 0;
  int wr_count    = 0;
  int sat_hi      = 0;
  int sat_lo      = 0;

  tb_clock_gen clock_gen (
    .clk     (clk),
    .reset_n (reset_n)
  );

  audio_mixer_top #(
    .NUM_VOICES  (NUM_VOICES)
  ) UUT (
    .clk         (clk),
    .reset_n     (reset_n),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .triggers    (triggers),
    .mem_addr    (mem_addr),
    .mem_rd_data (mem_rd_data),
    .fifo_full   (fifo_full),
    .fifo_wr_en  (fifo_wr_en),
    .fifo_data   (fifo_data)
  );

  // **************************************************
  // sample memory and reference model
  // **************************************************

  // hash of the full address, low 16 bits
  function automatic logic [DW-1:0] mem_word(input logic [AW-1:0] addr);
    logic [31:0] a;
    a = 32'(addr);
    return DW'((a * 32'h9e37) ^ (a >> 3));
  endfunction

  // same cycle read data
  assign mem_rd_data = mem_word(mem_addr);

  // unclamped signed sum over the playing voices
  function automatic int sum_voices();
    int sum;
    sum = 0;
    for (int v = 0; v < NUM_VOICES; v++) begin
      if (ref_active[v]) sum += int'($signed(mem_word(ref_addr[v])));
    end
    return sum;
  endfunction

  function automatic logic [DW-1:0] clamp_word(input int s);
    if (s > 32767) return 16'h7fff;
    if (s < -32768) return 16'h8000;
    return DW'(s);
  endfunction

  // lowest trigger bit picks the sample, lowest idle voice takes it
  function automatic void load_model(input logic [3:0] trig);
    int k;
    k = -1;
    for (int i = 3; i >= 0; i--) begin
      if (trig[i]) k = i;
    end
    if (k < 0 || tab_len[k] == '0) return;
    for (int v = 0; v < NUM_VOICES; v++) begin
      if (!ref_active[v]) begin
        ref_active[v] = 1'b1;
        ref_addr[v]   = tab_base[k];
        ref_last[v]   = tab_base[k] + tab_len[k] - 1'b1;
        return;
      end
    end
  endfunction

  // step every voice, retire after its last word
  function automatic void advance_model();
    for (int v = 0; v < NUM_VOICES; v++) begin
      if (ref_active[v] && ref_addr[v] == ref_last[v]) ref_active[v] = 1'b0;
      else if (ref_active[v]) ref_addr[v] = ref_addr[v] + 1'b1;
    end
  endfunction

  // first address at or above start with a loud word of the wanted sign
  function automatic logic [AW-1:0] find_loud(input logic [AW-1:0] start, input bit positive);
    logic [AW-1:0] a;
    int            w;
    a = start;
    for (int i = 0; i < 4096; i++) begin
      w = int'($signed(mem_word(a)));
      if (positive ? (w > 16384) : (w < -16384)) return a;
      a = a + 1'b1;
    end
    return a;
  endfunction

  function automatic int max_length();
    int m;
    m = 0;
    for (int k = 0; k < 4; k++) begin
      if (int'(tab_len[k]) > m) m = int'(tab_len[k]);
    end
    return m;
  endfunction

  // **************************************************
  // error reporting
  // **************************************************

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic expect_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp) else
      report_failure($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  // cycle limit
  always @(posedge clk) begin
    cycle_count++;
    assert (cycle_count < MAX_CYCLES) else
      report_failure("timeout, the run did not finish within the cycle limit");
  end

  // every fifo write against the model, then step the model
  always @(negedge clk) begin : check_writes
    int raw;
    if (reset_n && fifo_wr_en) begin
      assert (ref_active != '0) else
        report_failure("fifo write while no voice should be playing");
      raw = sum_voices();
      if (raw > 32767) sat_hi++;
      if (raw < -32768) sat_lo++;
      expect_value("fifo_data", fifo_data, clamp_word(raw));
      wr_count++;
      advance_model();
    end
  end

  // **************************************************
  // bus and stimulus tasks
  // **************************************************

  // setup then access phase, response taken at the closing edge
  task automatic apb_transfer(input logic wr, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;
    @(posedge clk);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    // no wait states, ever
    expect_value("pready", apb_rsp.pready, 1);
    @(negedge clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic check_read(input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    logic        err;
    apb_transfer(1'b0, addr, '0, rd, err);
    expect_value("pslverr", err, 0);
    expect_value($sformatf("prdata at 0x%h", addr), rd, exp);
  endtask

  task automatic set_sample(input int k, input logic [AW-1:0] base, input logic [AW-1:0] len);
    logic [31:0] rd;
    logic        err;
    apb_transfer(1'b1, 8'(8 * k), 32'(base), rd, err);
    expect_value("pslverr", err, 0);
    apb_transfer(1'b1, 8'(8 * k + 4), 32'(len), rd, err);
    expect_value("pslverr", err, 0);
    tab_base[k] = base;
    tab_len[k]  = len;
  endtask

  // all entries against the shadow, status idle
  task automatic check_table();
    for (int k = 0; k < 4; k++) begin
      check_read(8'(8 * k), 32'(tab_base[k]));
      check_read(8'(8 * k + 4), 32'(tab_len[k]));
    end
    check_read(mixer_pkg::REG_STATUS, 32'h0);
  endtask

  // long enough for a frame in flight to finish
  task automatic hold_fifo();
    @(negedge clk);
    fifo_full = 1'b1;
    repeat (FRAME) @(negedge clk);
  endtask

  task automatic release_fifo();
    @(negedge clk);
    fifo_full = 1'b0;
  endtask

  // one cycle pulse, the model loads with it
  task automatic pulse_trigger(input logic [3:0] t);
    @(negedge clk);
    triggers = t;
    load_model(t);
    @(negedge clk);
    triggers = '0;
  endtask

  // run until the model has no voice left, then the DUT must be idle too
  task automatic drain();
    while (ref_active != '0) @(negedge clk);
    repeat (FRAME) @(negedge clk);
    check_read(mixer_pkg::REG_STATUS, 32'h0);
  endtask

  // **************************************************
  // tests
  // **************************************************

  initial begin
    logic [31:0] rd;
    logic        err;
    int          n0;
    int          gap;
    void'($urandom(32'hf3807d51));
    apb_req    = '0;
    triggers   = '0;
    fifo_full  = 1'b0;
    ref_active = '0;
    for (int k = 0; k < 4; k++) begin
      tab_base[k] = '0;
      tab_len[k]  = '0;
    end
    @(posedge reset_n);

    // registers, reset value then readback
    check_table();
    for (int k = 0; k < 4; k++) set_sample(k, AW'($urandom), AW'($urandom));
    check_table();
    // unmapped, unaligned and read-only offsets
    apb_transfer(1'b1, 8'h24, 32'hffff_ffff, rd, err);
    expect_value("pslverr", err, 1);
    apb_transfer(1'b1, 8'h05, 32'hffff_ffff, rd, err);
    expect_value("pslverr", err, 1);
    apb_transfer(1'b0, 8'h24, '0, rd, err);
    expect_value("pslverr", err, 1);
    expect_value("prdata", rd, 0);
    apb_transfer(1'b1, mixer_pkg::REG_STATUS, 32'hf, rd, err);
    expect_value("pslverr", err, 0);
    check_table();

    // single voice plays its range in order
    for (int k = 0; k < 4; k++) set_sample(k, '0, '0);
    set_sample(0, AW'($urandom % 32'h20000), AW'(1 + $urandom % 24));
    n0 = wr_count;
    hold_fifo();
    pulse_trigger(4'b0001);
    release_fifo();
    drain();
    expect_value("write count", wr_count - n0, tab_len[0]);

    // four voices, loud positive pass then loud negative pass
    sat_hi = 0;
    sat_lo = 0;
    for (int pass = 0; pass < 2; pass++) begin
      for (int k = 0; k < 4; k++) begin
        set_sample(k, find_loud(AW'(k * 32'h8000 + $urandom % 32'h4000), pass == 0),
                   AW'(4 + 5 * k + $urandom % 5));
      end
      n0 = wr_count;
      hold_fifo();
      for (int k = 0; k < 4; k++) pulse_trigger(4'(1 << k));
      release_fifo();
      drain();
      // distinct lengths, so voices retire one by one
      expect_value("write count", wr_count - n0, tab_len[3]);
    end
    assert (sat_hi > 0 && sat_lo > 0) else
      report_failure("mixing never saturated in both directions");

    // two triggers together, sample 1 wins
    set_sample(1, 18'h00100, 18'd5);
    set_sample(2, 18'h00900, 18'd9);
    n0 = wr_count;
    hold_fifo();
    pulse_trigger(4'b0110);
    check_read(mixer_pkg::REG_STATUS, 32'h1);
    release_fifo();
    drain();
    expect_value("write count", wr_count - n0, 5);

    // fifth trigger with every voice busy is dropped
    for (int k = 0; k < 4; k++) begin
      set_sample(k, AW'(k * 32'h1000 + $urandom % 32'h800), AW'(1 + $urandom % 24));
    end
    n0 = wr_count;
    hold_fifo();
    for (int k = 0; k < 4; k++) pulse_trigger(4'(1 << k));
    pulse_trigger(4'b0001);
    check_read(mixer_pkg::REG_STATUS, 32'hf);
    release_fifo();
    drain();
    expect_value("write count", wr_count - n0, max_length());

    // zero length starts nothing
    set_sample(3, 18'h02000, '0);
    n0 = wr_count;
    hold_fifo();
    pulse_trigger(4'b1000);
    check_read(mixer_pkg::REG_STATUS, 32'h0);
    release_fifo();
    repeat (4 * FRAME) @(negedge clk);
    expect_value("write count", wr_count - n0, 0);

    // random back-pressure, nothing lost or repeated
    for (int k = 0; k < 4; k++) begin
      set_sample(k, AW'($urandom % 32'h20000), AW'(1 + $urandom % 24));
    end
    n0 = wr_count;
    hold_fifo();
    for (int k = 0; k < 4; k++) pulse_trigger(4'(1 << k));
    while (ref_active != '0) begin
      @(negedge clk);
      fifo_full = ($urandom % 2) == 1;
    end
    fifo_full = 1'b0;
    drain();
    expect_value("write count", wr_count - n0, max_length());

    // latency from release, then back to back spacing
    set_sample(0, 18'h03000, 18'd24);
    hold_fifo();
    pulse_trigger(4'b0001);
    repeat (3 * FRAME) begin
      @(negedge clk);
      expect_value("fifo_wr_en", fifo_wr_en, 0);
    end
    release_fifo();
    gap = 0;
    do begin
      @(negedge clk);
      gap++;
      // voice v sits on the memory bus in collect cycle v
      if (gap <= NUM_VOICES) begin
        expect_value("mem_addr", mem_addr, ref_addr[gap - 1]);
      end
    end while (!fifo_wr_en && gap < 4 * FRAME);
    expect_value("write latency", gap, NUM_VOICES + 1);
    gap = 0;
    do begin
      @(negedge clk);
      gap++;
    end while (!fifo_wr_en && gap < 4 * FRAME);
    expect_value("write spacing", gap, FRAME);
    drain();

    $display("Testbench passed");
    $finish;
  end

endmodule

// ==== tb.f ====
logic/mixer_pkg.sv
logic/sample_table_regs.sv
logic/voice_allocator.sv
logic/voice_tracker.sv
logic/mix_sequencer.sv
logic/audio_mixer_top.sv
bench/tb_clock_gen.sv
bench/audio_mixer_tb.sv
